// File: cpu_queue_regs.f
queue_regs_pkg.sv
queue_event_pkg.sv
stat_reg_file.sv
queue_event_deltas.sv
reg_update_fsm.sv
cpu_queue_regs.sv
cpu_queue_regs_assertions.sv
tb_cpu_queue_regs.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, verdict from the log

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
   --top-module tb_cpu_queue_regs -f cpu_queue_regs.f --Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

"./$BUILD_DIR/Vtb_cpu_queue_regs" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Simulation FAILED" "$LOG"; then
   echo "run failed, see $LOG"
   exit 1
fi
if [ $run_status -ne 0 ]; then
   echo "simulator exited with status $run_status"
   exit 1
fi
echo "run finished cleanly"
exit 0

// File: tb_cpu_queue_regs.sv
module tb_cpu_queue_regs
   import queue_regs_pkg::*;
   import queue_event_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD      = 8;
   localparam int RESET_CYCLES    = 16;
   // init sweep takes ten cycles, leave a little margin
   localparam int POST_RESET_IDLE = 12;
   localparam int RANDOM_EVENTS   = 48;
   localparam int PRESET_EVENTS   = 16;
   localparam int PLANNED_EVENTS  = RANDOM_EVENTS + PRESET_EVENTS;
   localparam int WATCHDOG_CYCLES = PLANNED_EVENTS * 40 + 2000;
   // two full scan periods plus slack
   localparam int SETTLE_CYCLES   = 2 * NUM_REGS + 4;
   localparam int ACK_TIMEOUT     = 8;
   localparam int MIN_EVENT_GAP   = 16;

   localparam reg_addr_t BAD_ADDRS [6] = '{8'd10, 8'd11, 8'd15, 8'h13, 8'h40, 8'hf9};

   logic      clk;
   logic      reset;
   host_req_t host_req;
   reg_data_t rd_data;
   logic      ack;
   rx_event_t rx_event;
   tx_event_t tx_event;
   logic      rx_queue_en;
   logic      tx_queue_en;

   // model counters, one per map index
   reg_data_t model_regs [NUM_REGS];

   // requests waiting for their ack
   string     pending_name [$];
   reg_data_t pending_exp [$];
   logic      pending_chk [$];

   cpu_queue_regs i_dut (
      .clk         (clk),
      .reset       (reset),
      .host_req    (host_req),
      .rd_data     (rd_data),
      .ack         (ack),
      .rx_event    (rx_event),
      .tx_event    (tx_event),
      .rx_queue_en (rx_queue_en),
      .tx_queue_en (tx_queue_en)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // ------------------------------
   // failure reporting
   // ------------------------------
   task automatic stop_on_failure(input string reason);
      $display("%s", reason);
      $display("Simulation FAILED");
      $fatal(1, "run stopped");
   endtask

   task automatic check_value(input string name, input reg_data_t got, input reg_data_t exp);
      if (got !== exp) begin
         $display("[ERROR] time %0t: %s got 32'h%08h expected 32'h%08h",
                  $time, name, got, exp);
         $display("Simulation FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   // ------------------------------
   // reference model
   // ------------------------------
   // anything at or above the map size is unmapped, upper bits included
   function automatic reg_data_t expected_reg(input reg_addr_t addr);
      if (addr >= reg_addr_t'(NUM_REGS)) begin
         return BAD_ADDR_DATA;
      end
      return model_regs[addr[REG_IDX_WIDTH-1:0]];
   endfunction

   task automatic apply_events(input rx_event_t rx, input tx_event_t tx);
      if (rx.good) begin
         model_regs[REG_RX_STORED]   += 32'd1;
         model_regs[REG_RX_IN_QUEUE] += 32'd1;
      end
      if (rx.dropped) begin
         model_regs[REG_RX_DROPPED_FULL] += 32'd1;
      end
      // rx bytes count when the packet leaves
      if (rx.pulled) begin
         model_regs[REG_RX_DEQUEUED]     += 32'd1;
         model_regs[REG_RX_IN_QUEUE]     -= 32'd1;
         model_regs[REG_RX_BYTES_PUSHED] += reg_data_t'(rx.byte_cnt);
      end
      if (tx.stored) begin
         model_regs[REG_TX_ENQUEUED]     += 32'd1;
         model_regs[REG_TX_IN_QUEUE]     += 32'd1;
         model_regs[REG_TX_BYTES_PUSHED] += reg_data_t'(tx.byte_cnt);
      end
      if (tx.sent) begin
         model_regs[REG_TX_SENT]     += 32'd1;
         model_regs[REG_TX_IN_QUEUE] -= 32'd1;
      end
   endtask

   // compare on the falling edge, away from the driving edge
   always @(negedge clk) begin
      if (ack) begin
         if (pending_name.size() == 0) begin
            stop_on_failure("ack seen with no host request outstanding");
         end else begin
            if (pending_chk[0]) begin
               check_value(pending_name[0], rd_data, pending_exp[0]);
            end
            void'(pending_name.pop_front());
            void'(pending_exp.pop_front());
            void'(pending_chk.pop_front());
         end
      end
   end

   // ------------------------------
   // stimulus tasks
   // ------------------------------
   task automatic host_access(input logic write, input reg_addr_t addr, input reg_data_t data,
                              input int hold_cycles, input string name);
      host_req_t req;
      int        waited;
      req.req     = 1'b1;
      req.rd_wr_l = !write;
      req.addr    = addr;
      req.wr_data = data;
      waited      = 0;
      pending_name.push_back(name);
      pending_exp.push_back(expected_reg(addr));
      pending_chk.push_back(!write);
      @(posedge clk);
      host_req <= req;
      do begin
         @(negedge clk);
         waited++;
      end while (!ack && waited < ACK_TIMEOUT);
      if (!ack) begin
         stop_on_failure("host request got no ack before the timeout");
      end
      // first falling edge is still inside the request cycle
      check_value("ack latency", reg_data_t'(waited - 1), 32'd1);
      if (write && addr < reg_addr_t'(NUM_REGS)) begin
         model_regs[addr[REG_IDX_WIDTH-1:0]] = data;
      end
      // req may stay high, only the edge counts
      repeat (hold_cycles) @(posedge clk);
      @(posedge clk);
      host_req <= '0;
      repeat (2) @(posedge clk);
   endtask

   task automatic check_enables();
      check_value("rx_queue_en", reg_data_t'(rx_queue_en),
                  reg_data_t'(!model_regs[REG_CONTROL][CTRL_RX_DISABLE_BIT]));
      check_value("tx_queue_en", reg_data_t'(tx_queue_en),
                  reg_data_t'(!model_regs[REG_CONTROL][CTRL_TX_DISABLE_BIT]));
   endtask

   task automatic settle_and_read_all(input string tag);
      int i;
      repeat (SETTLE_CYCLES) @(posedge clk);
      for (i = 0; i < NUM_REGS; i++) begin
         host_access(1'b0, reg_addr_t'(i), '0, 0, $sformatf("rd_data %s reg %0d", tag, i));
      end
   endtask

   // one pulse per side, then a quiet gap so deltas stay small
   task automatic random_event();
      rx_event_t rx;
      tx_event_t tx;
      int        pick;
      rx = '0;
      tx = '0;
      pick = $urandom_range(3, 0);
      case (pick)
         1:       rx.good    = 1'b1;
         2:       rx.dropped = 1'b1;
         3:       rx.pulled  = 1'b1;
         default: rx = '0;
      endcase
      rx.byte_cnt = byte_cnt_t'($urandom_range(4095, 1));
      pick = $urandom_range(2, 0);
      case (pick)
         1:       tx.stored = 1'b1;
         2:       tx.sent   = 1'b1;
         default: tx = '0;
      endcase
      tx.byte_cnt = byte_cnt_t'($urandom_range(4095, 1));
      @(posedge clk);
      rx_event <= rx;
      tx_event <= tx;
      apply_events(rx, tx);
      @(posedge clk);
      rx_event <= '0;
      tx_event <= '0;
      repeat (MIN_EVENT_GAP + $urandom_range(7, 0)) @(posedge clk);
   endtask

   // ------------------------------
   // test sequence
   // ------------------------------
   initial begin
      int i;
      void'($urandom(32'hdf3));
      reset    = 1'b1;
      host_req = '0;
      rx_event = '0;
      tx_event = '0;
      for (i = 0; i < NUM_REGS; i++) begin
         model_regs[i] = '0;
      end
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
      repeat (POST_RESET_IDLE) @(posedge clk);

      // everything cleared, both queues enabled
      check_enables();
      settle_and_read_all("init");

      // control bits drive the enables
      host_access(1'b1, reg_addr_t'(REG_CONTROL), 32'h0000_0001, 0, "control write");
      check_enables();
      host_access(1'b1, reg_addr_t'(REG_CONTROL), 32'ha5a5_5a56, 0, "control write");
      check_enables();
      host_access(1'b1, reg_addr_t'(REG_CONTROL), 32'h0000_0003, 0, "control write");
      check_enables();
      host_access(1'b1, reg_addr_t'(REG_CONTROL), 32'h1234_5670, 0, "control write");
      check_enables();
      host_access(1'b0, reg_addr_t'(REG_CONTROL), '0, 0, "rd_data control");

      // random traffic on both queues
      repeat (RANDOM_EVENTS) random_event();
      settle_and_read_all("events");

      // unmapped addresses
      for (i = 0; i < 6; i++) begin
         host_access(1'b1, BAD_ADDRS[i], 32'hffff_ffff, 0, "bad addr write");
         host_access(1'b0, BAD_ADDRS[i], '0, 0, $sformatf("rd_data addr 0x%02h", BAD_ADDRS[i]));
      end
      settle_and_read_all("after bad writes");

      // preset counters, then keep counting on top
      host_access(1'b1, reg_addr_t'(REG_RX_STORED), 32'h1000_0000, 0, "preset write");
      host_access(1'b1, reg_addr_t'(REG_RX_BYTES_PUSHED), 32'h0000_ff00, 0, "preset write");
      host_access(1'b1, reg_addr_t'(REG_TX_IN_QUEUE), 32'hffff_fff0, 0, "preset write");
      repeat (PRESET_EVENTS) random_event();
      settle_and_read_all("preset");

      // req held high for several cycles
      host_access(1'b0, reg_addr_t'(REG_TX_SENT), '0, 5, "rd_data held read");
      host_access(1'b1, reg_addr_t'(REG_TX_SENT), 32'h0000_0055, 4, "held write");
      settle_and_read_all("held");

      repeat (4) @(posedge clk);
      if (pending_name.size() != 0) begin
         stop_on_failure("a host request finished without an ack");
      end else begin
         $display("Simulation PASSED");
         $finish;
      end
   end

   // ------------------------------
   // watchdog
   // ------------------------------
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      stop_on_failure("watchdog expired before the test sequence finished");
   end

endmodule

// File: cpu_queue_regs_assertions.sv
module cpu_queue_regs_assertions
   import queue_regs_pkg::*;
(
   input logic      clk,
   input logic      reset,
   input host_req_t host_req,
   input logic      ack,
   input logic      rx_queue_en,
   input logic      tx_queue_en
);

   timeunit 1ns;
   timeprecision 1ps;

   // ack is a single-cycle pulse
   ack_one_cycle: assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
      else $error("ack stayed high for two cycles");

   // ack only in the cycle after a rising req
   ack_after_new_req: assert property (@(posedge clk) disable iff (reset)
      ack |-> ($past(host_req.req) && !$past(host_req.req, 2)))
      else $error("ack without a new request");

   // and every rising req gets one
   new_req_gets_ack: assert property (@(posedge clk) disable iff (reset)
      (host_req.req && !$past(host_req.req)) |=> ack)
      else $error("new request without ack");

   // ------------------------------
   // queue enables
   // ------------------------------
   // control clears on reset so both queues start enabled
   enables_after_reset: assert property (@(posedge clk)
      $fell(reset) |-> (rx_queue_en && tx_queue_en))
      else $error("queue enables not both high after reset");

   // writes count once the init sweep is over
   control_write_sets_enables: assert property (@(posedge clk) disable iff (reset)
      (host_req.req && !$past(host_req.req) && !host_req.rd_wr_l &&
       host_req.addr == reg_addr_t'(REG_CONTROL) && !$past(reset, NUM_REGS))
      |=> (rx_queue_en == !$past(host_req.wr_data[CTRL_RX_DISABLE_BIT])) &&
          (tx_queue_en == !$past(host_req.wr_data[CTRL_TX_DISABLE_BIT])))
      else $error("queue enables do not follow the control write");

   // no other request moves the enables
   enables_only_on_ctrl_write: assert property (@(posedge clk) disable iff (reset)
      (!$stable(rx_queue_en) || !$stable(tx_queue_en)) |->
      ($past(host_req.req) && !$past(host_req.req, 2) && !$past(host_req.rd_wr_l) &&
       $past(host_req.addr) == reg_addr_t'(REG_CONTROL)))
      else $error("queue enables changed without a control write");

endmodule

bind cpu_queue_regs cpu_queue_regs_assertions i_assertions (
   .clk         (clk),
   .reset       (reset),
   .host_req    (host_req),
   .ack         (ack),
   .rx_queue_en (rx_queue_en),
   .tx_queue_en (tx_queue_en)
);

// File: cpu_queue_regs.sv
module cpu_queue_regs
   import queue_regs_pkg::*;
   import queue_event_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  host_req_t host_req,
   output reg_data_t rd_data,
   output logic      ack,
   input  rx_event_t rx_event,
   input  tx_event_t tx_event,
   output logic      rx_queue_en,
   output logic      tx_queue_en
);

   localparam int BYTE_CNT_WIDTH = $bits(byte_cnt_t);

   // scanner to delta stage
   reg_idx_t  commit_idx;
   logic      commit_en;
   delta_t    commit_delta;

   // scanner to RAM
   reg_idx_t  ram_addr;
   logic      ram_wr_en;
   reg_data_t ram_wr_data;
   reg_data_t ram_rd_data;

   // ------------------------------
   // event deltas
   // ------------------------------
   queue_event_deltas #(
      .BYTE_CNT_WIDTH (BYTE_CNT_WIDTH)
   ) i_deltas (
      .clk          (clk),
      .reset        (reset),
      .rx_event     (rx_event),
      .tx_event     (tx_event),
      .commit_idx   (commit_idx),
      .commit_en    (commit_en),
      .commit_delta (commit_delta)
   );

   // ------------------------------
   // scanner and host port
   // ------------------------------
   reg_update_fsm #(
      .NUM_REGS (NUM_REGS)
   ) i_fsm (
      .clk          (clk),
      .reset        (reset),
      .host_req     (host_req),
      .rd_data      (rd_data),
      .ack          (ack),
      .ram_addr     (ram_addr),
      .ram_wr_en    (ram_wr_en),
      .ram_wr_data  (ram_wr_data),
      .ram_rd_data  (ram_rd_data),
      .commit_idx   (commit_idx),
      .commit_en    (commit_en),
      .commit_delta (commit_delta),
      .rx_queue_en  (rx_queue_en),
      .tx_queue_en  (tx_queue_en)
   );

   // counter storage
   stat_reg_file #(
      .DEPTH (NUM_REGS),
      .WIDTH (REG_DATA_WIDTH)
   ) i_ram (
      .clk     (clk),
      .addr    (ram_addr),
      .wr_en   (ram_wr_en),
      .wr_data (ram_wr_data),
      .rd_data (ram_rd_data)
   );

endmodule

// File: reg_update_fsm.sv
module reg_update_fsm
   import queue_regs_pkg::*;
   import queue_event_pkg::*;
#(
   parameter int NUM_REGS = 10
) (
   input  logic      clk,
   input  logic      reset,
   input  host_req_t host_req,
   output reg_data_t rd_data,
   output logic      ack,
   output reg_idx_t  ram_addr,
   output logic      ram_wr_en,
   output reg_data_t ram_wr_data,
   input  reg_data_t ram_rd_data,
   output reg_idx_t  commit_idx,
   output logic      commit_en,
   input  delta_t    commit_delta,
   output logic      rx_queue_en,
   output logic      tx_queue_en
);

   typedef enum logic {
      ST_INIT,
      ST_SCAN
   } state_e;

   state_e    state;
   reg_idx_t  scan_idx;
   logic      req_d1;
   logic      new_req;
   reg_idx_t  addr_idx;
   logic      addr_good;
   logic      host_wr;
   reg_data_t control;
   reg_data_t delta_ext;

   // ------------------------------
   // request decode
   // ------------------------------
   // first cycle of req after a low cycle
   assign new_req   = host_req.req && !req_d1;
   assign host_wr   = !host_req.rd_wr_l;
   assign addr_idx  = host_req.addr[REG_IDX_WIDTH-1:0];
   // upper bits must be zero and the index inside the map
   assign addr_good = (host_req.addr[REG_ADDR_WIDTH-1:REG_IDX_WIDTH] == '0) &&
                      (addr_idx < NUM_REGS);

   assign delta_ext = {{(REG_DATA_WIDTH-DELTA_WIDTH){commit_delta[DELTA_WIDTH-1]}},
                       commit_delta};

   // deltas look at the scan index, commit_en says whether it lands
   assign commit_idx = scan_idx;

   // ------------------------------
   // RAM port mux
   // ------------------------------
   always_comb begin
      ram_addr    = scan_idx;
      ram_wr_en   = 1'b0;
      ram_wr_data = ram_rd_data + delta_ext;
      commit_en   = 1'b0;
      case (state)
         ST_INIT: begin
            // clear one word per cycle
            ram_wr_en   = 1'b1;
            ram_wr_data = '0;
         end
         ST_SCAN: begin
            if (new_req) begin
               // host owns the port, scan waits a cycle
               ram_addr    = addr_idx;
               ram_wr_en   = addr_good && host_wr;
               ram_wr_data = host_req.wr_data;
            end else begin
               // read-modify-write of the scanned word
               ram_wr_en = 1'b1;
               commit_en = 1'b1;
            end
         end
         default: begin
            ram_wr_en = 1'b0;
         end
      endcase
   end

   // ------------------------------
   // state, scan index, control
   // ------------------------------
   always_ff @(posedge clk) begin
      req_d1 <= host_req.req;
      if (reset) begin
         state    <= ST_INIT;
         scan_idx <= '0;
         control  <= '0;
      end else begin
         case (state)
            ST_INIT: begin
               if (scan_idx == reg_idx_t'(NUM_REGS - 1)) begin
                  state    <= ST_SCAN;
                  scan_idx <= '0;
               end else begin
                  scan_idx <= scan_idx + 1'b1;
               end
            end
            ST_SCAN: begin
               if (new_req) begin
                  // control copy follows the RAM word
                  if (addr_good && host_wr && addr_idx == REG_CONTROL) begin
                     control <= host_req.wr_data;
                  end
               end else if (scan_idx == reg_idx_t'(NUM_REGS - 1)) begin
                  scan_idx <= '0;
               end else begin
                  scan_idx <= scan_idx + 1'b1;
               end
            end
            default: begin
               state <= ST_INIT;
            end
         endcase
      end
   end

   // ------------------------------
   // host response
   // ------------------------------
   // data and ack one cycle after the new request
   always_ff @(posedge clk) begin
      if (reset) begin
         rd_data <= '0;
         ack     <= 1'b0;
      end else begin
         if (new_req) begin
            rd_data <= addr_good ? ram_rd_data : BAD_ADDR_DATA;
         end
         ack <= new_req;
      end
   end

   // set bit disables the queue
   assign rx_queue_en = !control[CTRL_RX_DISABLE_BIT];
   assign tx_queue_en = !control[CTRL_TX_DISABLE_BIT];

endmodule

// File: queue_event_deltas.sv
module queue_event_deltas
   import queue_regs_pkg::*;
   import queue_event_pkg::*;
#(
   parameter int BYTE_CNT_WIDTH = 12
) (
   input  logic      clk,
   input  logic      reset,
   input  rx_event_t rx_event,
   input  tx_event_t tx_event,
   input  reg_idx_t  commit_idx,
   input  logic      commit_en,
   output delta_t    commit_delta
);

   localparam int NUM_IDX = 2 ** $bits(reg_idx_t);

   // one-hot of the counter being committed this cycle
   logic [NUM_IDX-1:0] commit_hit;

   // packet deltas
   logic [PKT_DELTA_WIDTH-1:0] rx_stored_delta;
   logic [PKT_DELTA_WIDTH-1:0] rx_dropped_delta;
   logic [PKT_DELTA_WIDTH-1:0] rx_dequeued_delta;
   logic [PKT_DELTA_WIDTH-1:0] tx_enqueued_delta;
   logic [PKT_DELTA_WIDTH-1:0] tx_sent_delta;

   // byte deltas
   logic [BYTE_CNT_WIDTH-1:0] rx_byte_delta;
   logic [BYTE_CNT_WIDTH-1:0] tx_byte_delta;

   // in-queue deltas, two's complement
   logic [QUEUE_DELTA_WIDTH-1:0] rx_queue_delta;
   logic [QUEUE_DELTA_WIDTH-1:0] tx_queue_delta;

   // ------------------------------
   // next-value helpers
   // ------------------------------
   // a committed delta restarts from this cycle's event
   function automatic logic [PKT_DELTA_WIDTH-1:0] pkt_delta_next(
      input logic [PKT_DELTA_WIDTH-1:0] delta,
      input logic                       event_pulse,
      input logic                       commit
   );
      logic [PKT_DELTA_WIDTH-1:0] base;
      base = commit ? '0 : delta;
      return base + event_pulse;
   endfunction

   function automatic logic [BYTE_CNT_WIDTH-1:0] byte_delta_next(
      input logic [BYTE_CNT_WIDTH-1:0] delta,
      input logic                      event_pulse,
      input byte_cnt_t                 byte_cnt,
      input logic                      commit
   );
      logic [BYTE_CNT_WIDTH-1:0] base;
      base = commit ? '0 : delta;
      return event_pulse ? base + byte_cnt : base;
   endfunction

   // up and down in the same cycle cancel
   function automatic logic [QUEUE_DELTA_WIDTH-1:0] queue_delta_next(
      input logic [QUEUE_DELTA_WIDTH-1:0] delta,
      input logic                         up,
      input logic                         down,
      input logic                         commit
   );
      logic [QUEUE_DELTA_WIDTH-1:0] base;
      base = commit ? '0 : delta;
      case ({down, up})
         2'b01:   return base + 1'b1;
         2'b10:   return base - 1'b1;
         default: return base;
      endcase
   endfunction

   assign commit_hit = commit_en ? (NUM_IDX'(1) << commit_idx) : '0;

   // ------------------------------
   // delta registers
   // ------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         rx_stored_delta   <= '0;
         rx_dropped_delta  <= '0;
         rx_dequeued_delta <= '0;
         tx_enqueued_delta <= '0;
         tx_sent_delta     <= '0;
         rx_byte_delta     <= '0;
         tx_byte_delta     <= '0;
         rx_queue_delta    <= '0;
         tx_queue_delta    <= '0;
      end else begin
         rx_stored_delta   <= pkt_delta_next(rx_stored_delta, rx_event.good,
                                             commit_hit[REG_RX_STORED]);
         rx_dropped_delta  <= pkt_delta_next(rx_dropped_delta, rx_event.dropped,
                                             commit_hit[REG_RX_DROPPED_FULL]);
         rx_dequeued_delta <= pkt_delta_next(rx_dequeued_delta, rx_event.pulled,
                                             commit_hit[REG_RX_DEQUEUED]);
         tx_enqueued_delta <= pkt_delta_next(tx_enqueued_delta, tx_event.stored,
                                             commit_hit[REG_TX_ENQUEUED]);
         tx_sent_delta     <= pkt_delta_next(tx_sent_delta, tx_event.sent,
                                             commit_hit[REG_TX_SENT]);
         // rx bytes on pull, tx bytes on store
         rx_byte_delta     <= byte_delta_next(rx_byte_delta, rx_event.pulled,
                                              rx_event.byte_cnt,
                                              commit_hit[REG_RX_BYTES_PUSHED]);
         tx_byte_delta     <= byte_delta_next(tx_byte_delta, tx_event.stored,
                                              tx_event.byte_cnt,
                                              commit_hit[REG_TX_BYTES_PUSHED]);
         rx_queue_delta    <= queue_delta_next(rx_queue_delta, rx_event.good,
                                               rx_event.pulled,
                                               commit_hit[REG_RX_IN_QUEUE]);
         tx_queue_delta    <= queue_delta_next(tx_queue_delta, tx_event.stored,
                                               tx_event.sent,
                                               commit_hit[REG_TX_IN_QUEUE]);
      end
   end

   // ------------------------------
   // delta select
   // ------------------------------
   // packet and byte deltas zero-extend, in-queue deltas sign-extend
   always_comb begin
      case (commit_idx)
         REG_RX_STORED:
            commit_delta = {{(DELTA_WIDTH-PKT_DELTA_WIDTH){1'b0}}, rx_stored_delta};
         REG_RX_DROPPED_FULL:
            commit_delta = {{(DELTA_WIDTH-PKT_DELTA_WIDTH){1'b0}}, rx_dropped_delta};
         REG_RX_DEQUEUED:
            commit_delta = {{(DELTA_WIDTH-PKT_DELTA_WIDTH){1'b0}}, rx_dequeued_delta};
         REG_RX_BYTES_PUSHED:
            commit_delta = {{(DELTA_WIDTH-BYTE_CNT_WIDTH){1'b0}}, rx_byte_delta};
         REG_RX_IN_QUEUE:
            commit_delta = {{(DELTA_WIDTH-QUEUE_DELTA_WIDTH){rx_queue_delta[2]}},
                            rx_queue_delta};
         REG_TX_ENQUEUED:
            commit_delta = {{(DELTA_WIDTH-PKT_DELTA_WIDTH){1'b0}}, tx_enqueued_delta};
         REG_TX_SENT:
            commit_delta = {{(DELTA_WIDTH-PKT_DELTA_WIDTH){1'b0}}, tx_sent_delta};
         REG_TX_BYTES_PUSHED:
            commit_delta = {{(DELTA_WIDTH-BYTE_CNT_WIDTH){1'b0}}, tx_byte_delta};
         REG_TX_IN_QUEUE:
            commit_delta = {{(DELTA_WIDTH-QUEUE_DELTA_WIDTH){tx_queue_delta[2]}},
                            tx_queue_delta};
         // control and unmapped indices add nothing
         default:
            commit_delta = '0;
      endcase
   end

endmodule

// File: stat_reg_file.sv
module stat_reg_file
   import queue_regs_pkg::*;
#(
   parameter int DEPTH = 10,
   parameter int WIDTH = 32
) (
   input  logic      clk,
   input  reg_idx_t  addr,
   input  logic      wr_en,
   input  reg_data_t wr_data,
   output reg_data_t rd_data
);

   // counter words, no reset, the init sweep clears them
   logic [WIDTH-1:0] mem [DEPTH];

   // write on the edge
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[addr] <= wr_data;
      end
   end

   // combinational read
   // read, add and write back all in one cycle
   assign rd_data = mem[addr];

endmodule

// File: queue_event_pkg.sv
package queue_event_pkg;

   // packet length in bytes, up to 4095
   typedef logic [11:0] byte_cnt_t;

   // ------------------------------
   // delta widths
   // ------------------------------
   // one scan period is short enough for at most two packets
   localparam int PKT_DELTA_WIDTH   = 2;
   // signed in-queue change
   localparam int QUEUE_DELTA_WIDTH = 3;
   // byte delta plus a sign bit
   localparam int DELTA_WIDTH       = 13;

   typedef logic signed [DELTA_WIDTH-1:0] delta_t;

   // rx side, bytes are counted when a packet is pulled
   typedef struct packed {
      logic      good;
      logic      dropped;
      logic      pulled;
      byte_cnt_t byte_cnt;
   } rx_event_t;

   // tx side, bytes are counted when a packet is stored
   typedef struct packed {
      logic      stored;
      logic      sent;
      byte_cnt_t byte_cnt;
   } tx_event_t;

endpackage

// File: queue_regs_pkg.sv
package queue_regs_pkg;

   // ------------------------------
   // host port widths
   // ------------------------------
   localparam int REG_DATA_WIDTH = 32;
   localparam int REG_ADDR_WIDTH = 8;
   // low address bits that select a word in the map
   localparam int REG_IDX_WIDTH  = 4;

   typedef logic [REG_DATA_WIDTH-1:0] reg_data_t;
   typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
   typedef logic [REG_IDX_WIDTH-1:0]  reg_idx_t;

   // ------------------------------
   // register map
   // ------------------------------
   localparam int NUM_REGS = 10;

   typedef enum logic [REG_IDX_WIDTH-1:0] {
      REG_CONTROL         = 4'd0,
      REG_RX_STORED       = 4'd1,
      REG_RX_DROPPED_FULL = 4'd2,
      REG_RX_DEQUEUED     = 4'd3,
      REG_RX_BYTES_PUSHED = 4'd4,
      REG_RX_IN_QUEUE     = 4'd5,
      REG_TX_ENQUEUED     = 4'd6,
      REG_TX_SENT         = 4'd7,
      REG_TX_BYTES_PUSHED = 4'd8,
      REG_TX_IN_QUEUE     = 4'd9
   } reg_idx_e;

   // control word bits, a set bit stops that queue
   localparam int CTRL_RX_DISABLE_BIT = 0;
   localparam int CTRL_TX_DISABLE_BIT = 1;

   // read data for addresses outside the map
   localparam reg_data_t BAD_ADDR_DATA = 32'hdead_beef;

   // one host request, rd_wr_l low means write
   typedef struct packed {
      logic      req;
      logic      rd_wr_l;
      reg_addr_t addr;
      reg_data_t wr_data;
   } host_req_t;

endpackage
